// File: source/blit_cmd_pkg.sv
// Command word layout, count width and status type shared by the blitter sequencer and its testbench
package blit_cmd_pkg;

	// Flag positions in the 32-bit command word
	localparam int CMD_HOLD_BIT    = 7;
	localparam int CMD_UPD_A1F_BIT = 8;
	localparam int CMD_UPD_A1_BIT  = 9;
	localparam int CMD_UPD_A2_BIT  = 10;
	localparam int CMD_BUS_HI_BIT  = 29;

	// Outer and inner loop counts
	localparam int COUNT_W = 16;
	typedef logic [COUNT_W-1:0] count_t;

	// Latched command flags
	typedef struct packed {
		logic upd_a1f;
		logic upd_a1;
		logic upd_a2;
		logic bus_hi;
		logic hold;
	} cmd_t;

	// Sequencer state as seen on the status port, one-hot
	typedef struct packed {
		logic idle;
		logic inner;
		logic a1f_update;
		logic a1_update;
		logic a2_update;
	} status_t;

endpackage

// File: source/blit_addr_pkg.sv
// Pointer and step types for the A1 and A2 address registers of the blitter
package blit_addr_pkg;

	// A1 carries a fraction, A2 is integer only
	localparam int PTR_INT_W  = 16;
	localparam int PTR_FRAC_W = 16;

	// Integer part in the upper half, fraction in the lower half
	typedef struct packed {
		logic [PTR_INT_W-1:0]  int_part;
		logic [PTR_FRAC_W-1:0] frac;
	} ptr_a1_t;

	typedef logic [PTR_INT_W-1:0] ptr_a2_t;

	// Between-line step values
	typedef struct packed {
		ptr_a1_t              a1_step;
		logic [PTR_INT_W-1:0] a2_step;
	} step_t;

endpackage

// File: source/blit_cmd_regs.sv
// Blitter register block: turns write strobes into command flags, counts, steps and a start pulse
`timescale 1ns/100ps

module blit_cmd_regs (
	input  logic                 sys_clk,
	input  logic                 resetl,
	input  logic                 cmd_wr,
	input  logic                 count_wr,
	input  logic                 a1_step_wr,
	input  logic                 a2_step_wr,
	input  logic [31:0]          din,
	input  logic                 idle,
	output blit_cmd_pkg::cmd_t   cmd,
	output logic                 outer_load,
	output blit_cmd_pkg::count_t outer_count,
	output blit_cmd_pkg::count_t inner_count,
	output blit_addr_pkg::step_t step,
	output logic                 start
);
	import blit_cmd_pkg::*;

	// Command write seen one cycle late, so the flags are already latched
	logic cmd_ld;

	// Command flags and write tracking
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cmd <= '0;
			cmd_ld <= 1'b0;
			outer_load <= 1'b0;
		end else begin
			cmd_ld <= cmd_wr;
			outer_load <= count_wr;
			if (cmd_wr) begin
				cmd.upd_a1f <= din[CMD_UPD_A1F_BIT];
				cmd.upd_a1 <= din[CMD_UPD_A1_BIT];
				cmd.upd_a2 <= din[CMD_UPD_A2_BIT];
				cmd.bus_hi <= din[CMD_BUS_HI_BIT];
				cmd.hold <= din[CMD_HOLD_BIT];
			end
		end
	end

	// Counts, outer in the top half and inner in the bottom half
	always_ff @(posedge sys_clk) begin
		if (count_wr) begin
			outer_count <= din[31:16];
			inner_count <= din[15:0];
		end
	end

	// Step values
	always_ff @(posedge sys_clk) begin
		if (a1_step_wr)
			step.a1_step <= din;
		if (a2_step_wr)
			step.a2_step <= din[15:0];
	end

	// Go only when not held and the sequencer is free
	// a command written mid-blit just updates the flags
	assign start = cmd_ld && !cmd.hold && idle;

endmodule

// File: source/blit_outer.sv
// Blitter outer loop: line sequencing, update phases, outer line count, bus request and interrupt
`timescale 1ns/100ps

module blit_outer (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  blit_cmd_pkg::cmd_t    cmd,
	input  logic                  start,
	input  logic                  outer_load,
	input  blit_cmd_pkg::count_t  outer_count,
	input  logic                  in_done,
	input  logic                  in_active,
	input  logic                  stopped,
	output logic                  in_start,
	output logic                  a1f_upd,
	output logic                  a1_upd,
	output logic                  a2_upd,
	output logic [1:0]            breq,
	output logic                  blit_int,
	output blit_cmd_pkg::status_t status
);
	import blit_cmd_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INNER,
		ST_A1F,
		ST_A1,
		ST_A2
	} state_t;

	state_t state;
	state_t state_nxt;
	count_t ocount;
	logic outer0;
	logic launch;
	logic busy;
	logic idle_now;
	logic idled;

	// Last line already started
	assign outer0 = (ocount == '0);

	// Next state, launch marks the cycle before each in_start
	always_comb begin
		state_nxt = state;
		launch = 1'b0;
		case (state)
			ST_IDLE: begin
				if (start) begin
					state_nxt = ST_INNER;
					launch = 1'b1;
				end
			end
			ST_INNER: begin
				if (in_done) begin
					if (outer0)
						state_nxt = ST_IDLE;
					else if (cmd.upd_a1f)
						state_nxt = ST_A1F;
					else if (cmd.upd_a1)
						state_nxt = ST_A1;
					else if (cmd.upd_a2)
						state_nxt = ST_A2;
					else
						launch = 1'b1;
				end
			end
			ST_A1F: begin
				// Fraction first, then integer, then A2
				if (cmd.upd_a1) begin
					state_nxt = ST_A1;
				end else if (cmd.upd_a2) begin
					state_nxt = ST_A2;
				end else begin
					state_nxt = ST_INNER;
					launch = 1'b1;
				end
			end
			ST_A1: begin
				if (cmd.upd_a2) begin
					state_nxt = ST_A2;
				end else begin
					state_nxt = ST_INNER;
					launch = 1'b1;
				end
			end
			ST_A2: begin
				state_nxt = ST_INNER;
				launch = 1'b1;
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= ST_IDLE;
			in_start <= 1'b0;
		end else begin
			state <= state_nxt;
			in_start <= launch;
		end
	end

	// Outer line counter, one count per line started
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			ocount <= '0;
		else if (outer_load)
			ocount <= outer_count;
		else if (in_start)
			ocount <= ocount - COUNT_W'(1);
	end

	// Update strobes, one cycle each
	assign a1f_upd = (state == ST_A1F);
	assign a1_upd = (state == ST_A1);
	assign a2_upd = (state == ST_A2);

	assign status.idle = (state == ST_IDLE);
	assign status.inner = (state == ST_INNER);
	assign status.a1f_update = a1f_upd;
	assign status.a1_update = a1_upd;
	assign status.a2_update = a2_upd;

	// Bus request level, priority picked by bus_hi
	assign busy = !status.idle || in_active;
	assign breq[0] = busy && !stopped && !cmd.bus_hi;
	assign breq[1] = busy && !stopped && cmd.bus_hi;

	// Interrupt on the rising edge of fully idle
	assign idle_now = status.idle && !in_active;

	always_ff @(posedge sys_clk) begin
		if (!resetl)
			idled <= 1'b1;
		else
			idled <= idle_now;
	end

	assign blit_int = idle_now && !idled;

endmodule

// File: source/blit_inner.sv
// Blitter inner loop model: counts the pixels of one line and flags its completion
`timescale 1ns/100ps

module blit_inner (
	input  logic                 sys_clk,
	input  logic                 resetl,
	input  logic                 in_start,
	input  blit_cmd_pkg::count_t inner_count,
	output logic                 in_done,
	output logic                 in_active
);
	import blit_cmd_pkg::*;

	// Pixels left in the current line, including the one in progress
	count_t pix_cnt;
	logic active;
	logic last_pix;

	assign last_pix = (pix_cnt == COUNT_W'(1));

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pix_cnt <= '0;
			active <= 1'b0;
		end else if (in_start) begin
			// Latch the line length
			pix_cnt <= inner_count;
			active <= 1'b1;
		end else if (active) begin
			pix_cnt <= pix_cnt - COUNT_W'(1);
			if (last_pix)
				active <= 1'b0;
		end
	end

	// Done on the last pixel, inner_count cycles after in_start
	assign in_done = active && last_pix;
	assign in_active = active;

endmodule

// File: source/blit_addr_update.sv
// Blitter address registers: A1 and A2 pointers loaded by writes and stepped between lines
`timescale 1ns/100ps

module blit_addr_update (
	input  logic                   sys_clk,
	input  logic                   resetl,
	input  logic                   a1_ptr_wr,
	input  logic                   a2_ptr_wr,
	input  logic [31:0]            din,
	input  blit_addr_pkg::step_t   step,
	input  logic                   a1f_upd,
	input  logic                   a1_upd,
	input  logic                   a2_upd,
	output blit_addr_pkg::ptr_a1_t a1_ptr,
	output blit_addr_pkg::ptr_a2_t a2_ptr
);
	import blit_addr_pkg::*;

	// Fraction sum with carry out on top
	logic [PTR_FRAC_W:0] frac_sum;
	logic [PTR_INT_W-1:0] frac_carry;

	assign frac_sum = {1'b0, a1_ptr.frac} + {1'b0, step.a1_step.frac};
	assign frac_carry = PTR_INT_W'(frac_sum[PTR_FRAC_W]);

	// A1 pointer
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			a1_ptr <= '0;
		end else if (a1_ptr_wr) begin
			a1_ptr <= din;
		end else if (a1f_upd) begin
			// Carry goes into the integer part here only
			a1_ptr.frac <= frac_sum[PTR_FRAC_W-1:0];
			a1_ptr.int_part <= a1_ptr.int_part + frac_carry;
		end else if (a1_upd) begin
			a1_ptr.int_part <= a1_ptr.int_part + step.a1_step.int_part;
		end
	end

	// A2 pointer, integer step only
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			a2_ptr <= '0;
		else if (a2_ptr_wr)
			a2_ptr <= din[PTR_INT_W-1:0];
		else if (a2_upd)
			a2_ptr <= a2_ptr + step.a2_step;
	end

endmodule

// File: source/blit_core.sv
// Blitter outer-loop top level: registers, sequencer, inner counter and pointer stepper
`timescale 1ns/100ps

module blit_core (
	input  logic                   sys_clk,
	input  logic                   resetl,
	input  logic                   cmd_wr,
	input  logic                   count_wr,
	input  logic                   a1_step_wr,
	input  logic                   a2_step_wr,
	input  logic                   a1_ptr_wr,
	input  logic                   a2_ptr_wr,
	input  logic [31:0]            din,
	input  logic                   stopped,
	output logic [1:0]             breq,
	output logic                   blit_int,
	output blit_cmd_pkg::status_t  status,
	output blit_addr_pkg::ptr_a1_t a1_ptr,
	output blit_addr_pkg::ptr_a2_t a2_ptr
);
	import blit_cmd_pkg::*;
	import blit_addr_pkg::*;

	// Register block outputs
	cmd_t cmd;
	logic outer_load;
	count_t outer_count;
	count_t inner_count;
	step_t step;
	logic start;

	// Sequencer to inner loop and pointers
	logic in_start;
	logic in_done;
	logic in_active;
	logic a1f_upd;
	logic a1_upd;
	logic a2_upd;

	blit_cmd_regs blit_cmd_regs_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.cmd_wr      (cmd_wr),
		.count_wr    (count_wr),
		.a1_step_wr  (a1_step_wr),
		.a2_step_wr  (a2_step_wr),
		.din         (din),
		.idle        (status.idle),
		.cmd         (cmd),
		.outer_load  (outer_load),
		.outer_count (outer_count),
		.inner_count (inner_count),
		.step        (step),
		.start       (start)
	);

	blit_outer blit_outer_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.cmd         (cmd),
		.start       (start),
		.outer_load  (outer_load),
		.outer_count (outer_count),
		.in_done     (in_done),
		.in_active   (in_active),
		.stopped     (stopped),
		.in_start    (in_start),
		.a1f_upd     (a1f_upd),
		.a1_upd      (a1_upd),
		.a2_upd      (a2_upd),
		.breq        (breq),
		.blit_int    (blit_int),
		.status      (status)
	);

	blit_inner blit_inner_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.in_start    (in_start),
		.inner_count (inner_count),
		.in_done     (in_done),
		.in_active   (in_active)
	);

	blit_addr_update blit_addr_update_inst (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.a1_ptr_wr (a1_ptr_wr),
		.a2_ptr_wr (a2_ptr_wr),
		.din       (din),
		.step      (step),
		.a1f_upd   (a1f_upd),
		.a1_upd    (a1_upd),
		.a2_upd    (a2_upd),
		.a1_ptr    (a1_ptr),
		.a2_ptr    (a2_ptr)
	);

endmodule

// File: tests/blit_core_assert.sv
// Concurrent checks on the blitter sequencer, bound into every blit_outer instance
`timescale 1ns/100ps

module blit_core_assert (
	input logic                  sys_clk,
	input logic                  resetl,
	input logic                  start,
	input logic                  in_start,
	input logic                  a1f_upd,
	input logic                  a1_upd,
	input logic                  a2_upd,
	input logic [1:0]            breq,
	input logic                  blit_int,
	input logic                  in_done,
	input logic                  in_active,
	input blit_cmd_pkg::status_t status
);

	// Line start and update strobes never overlap
	strobe_onehot: assert property (@(posedge sys_clk) disable iff (!resetl)
		$onehot0({in_start, a1f_upd, a1_upd, a2_upd}))
		else $error("Sequencer strobes overlap");

	// Interrupt follows the end of the last line and lasts a single cycle
	int_one_cycle: assert property (@(posedge sys_clk) disable iff (!resetl)
		blit_int |-> $past(in_done) ##1 !blit_int)
		else $error("blit_int not a single pulse after the last line");

	// Fully idle with no start leaves the bus request low
	breq_when_idle: assert property (@(posedge sys_clk) disable iff (!resetl)
		(status.idle && !in_active && !start) |=> (breq == 2'b00))
		else $error("Bus request raised while idle");

endmodule

bind blit_outer blit_core_assert blit_core_assert_inst (
	.sys_clk   (sys_clk),
	.resetl    (resetl),
	.start     (start),
	.in_start  (in_start),
	.a1f_upd   (a1f_upd),
	.a1_upd    (a1_upd),
	.a2_upd    (a2_upd),
	.breq      (breq),
	.blit_int  (blit_int),
	.in_done   (in_done),
	.in_active (in_active),
	.status    (status)
);

// File: tests/blit_core_tb.sv
// Testbench for the blitter outer-loop sequencer; run with files.f, blit_core_tb is the top module
`timescale 1ns/100ps

module blit_core_tb;
	import blit_cmd_pkg::*;
	import blit_addr_pkg::*;

	// Register select codes for write_reg
	localparam int SEL_CMD     = 0;
	localparam int SEL_COUNT   = 1;
	localparam int SEL_A1_STEP = 2;
	localparam int SEL_A2_STEP = 3;
	localparam int SEL_A1_PTR  = 4;
	localparam int SEL_A2_PTR  = 5;

	// Wait limits in clock cycles
	localparam int INT_TIMEOUT  = 200;
	localparam int BUSY_TIMEOUT = 20;

	// Final pointers of one blit
	typedef struct packed {
		ptr_a1_t a1;
		ptr_a2_t a2;
	} ptrs_t;

	logic sys_clk;
	logic resetl;
	logic cmd_wr;
	logic count_wr;
	logic a1_step_wr;
	logic a2_step_wr;
	logic a1_ptr_wr;
	logic a2_ptr_wr;
	logic [31:0] din;
	logic stopped;
	logic [1:0] breq;
	logic blit_int;
	status_t status;
	ptr_a1_t a1_ptr;
	ptr_a2_t a2_ptr;

	integer seed = 81;
	int val_errs = 0;
	int other_errs = 0;
	int int_cnt = 0;
	string test_name = "reset";
	status_t idle_only;
	// Expected pointers, one entry per blit in flight
	ptrs_t exp_q[$];

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;

	blit_core blit_core_inst (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.cmd_wr     (cmd_wr),
		.count_wr   (count_wr),
		.a1_step_wr (a1_step_wr),
		.a2_step_wr (a2_step_wr),
		.a1_ptr_wr  (a1_ptr_wr),
		.a2_ptr_wr  (a2_ptr_wr),
		.din        (din),
		.stopped    (stopped),
		.breq       (breq),
		.blit_int   (blit_int),
		.status     (status),
		.a1_ptr     (a1_ptr),
		.a2_ptr     (a2_ptr)
	);

	task automatic check_ptr_a1(input string name, input ptr_a1_t exp, input ptr_a1_t act);
		if (act !== exp) begin
			$display("ERR %s A1 expected %h actual %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_ptr_a2(input string name, input ptr_a2_t exp, input ptr_a2_t act);
		if (act !== exp) begin
			$display("ERR %s A2 expected %h actual %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_status(input string name, input status_t exp, input status_t act);
		if (act !== exp) begin
			$display("ERR %s status expected %b actual %b", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_breq(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("ERR %s breq expected %b actual %b", name, exp, act);
			val_errs++;
		end
	endtask

	// Pointers after n-1 update rounds, A1 treated as one 32-bit fixed-point value
	function automatic ptrs_t blit_model(input count_t n, input cmd_t flags, input ptr_a1_t a1,
		input ptr_a2_t a2, input step_t st);
		ptrs_t r;
		logic [31:0] a1_fix;
		int i;
		a1_fix = a1;
		r.a2 = a2;
		for (i = 1; i < int'(n); i++) begin
			// Fraction overflow lands in the integer half by itself
			if (flags.upd_a1f)
				a1_fix = a1_fix + {16'h0000, st.a1_step.frac};
			if (flags.upd_a1)
				a1_fix = a1_fix + {st.a1_step.int_part, 16'h0000};
			if (flags.upd_a2)
				r.a2 = r.a2 + st.a2_step;
		end
		r.a1 = a1_fix;
		return r;
	endfunction

	task automatic next_cycle();
		@(posedge sys_clk);
		#1;
	endtask

	// One-cycle write strobe carrying data
	task automatic write_reg(input int sel, input logic [31:0] data);
		din = data;
		case (sel)
			SEL_CMD:     cmd_wr = 1'b1;
			SEL_COUNT:   count_wr = 1'b1;
			SEL_A1_STEP: a1_step_wr = 1'b1;
			SEL_A2_STEP: a2_step_wr = 1'b1;
			SEL_A1_PTR:  a1_ptr_wr = 1'b1;
			SEL_A2_PTR:  a2_ptr_wr = 1'b1;
			default: ;
		endcase
		next_cycle();
		cmd_wr = 1'b0;
		count_wr = 1'b0;
		a1_step_wr = 1'b0;
		a2_step_wr = 1'b0;
		a1_ptr_wr = 1'b0;
		a2_ptr_wr = 1'b0;
	endtask

	task automatic wait_int(input int limit, output bit got);
		int start_cnt;
		int cycles;
		start_cnt = int_cnt;
		cycles = 0;
		got = 1'b0;
		while (!got && cycles < limit) begin
			next_cycle();
			cycles++;
			if (int_cnt != start_cnt)
				got = 1'b1;
		end
	endtask

	// Returns on a falling edge once the sequencer has left idle
	task automatic wait_busy(output bit got);
		int cycles;
		cycles = 0;
		got = 1'b0;
		while (!got && cycles < BUSY_TIMEOUT) begin
			@(negedge sys_clk);
			cycles++;
			if (!status.idle)
				got = 1'b1;
		end
	endtask

	task automatic run_blit(input count_t n, input count_t inner, input cmd_t flags,
		input ptr_a1_t a1, input ptr_a2_t a2, input step_t st, input logic stop);
		logic [31:0] cmd_word;
		logic [1:0] exp_breq;
		bit got;
		cmd_word = '0;
		cmd_word[CMD_UPD_A1F_BIT] = flags.upd_a1f;
		cmd_word[CMD_UPD_A1_BIT] = flags.upd_a1;
		cmd_word[CMD_UPD_A2_BIT] = flags.upd_a2;
		cmd_word[CMD_BUS_HI_BIT] = flags.bus_hi;
		// Request level while running
		if (stop)
			exp_breq = 2'b00;
		else if (flags.bus_hi)
			exp_breq = 2'b10;
		else
			exp_breq = 2'b01;
		exp_q.push_back(blit_model(n, flags, a1, a2, st));
		stopped = stop;
		write_reg(SEL_A1_STEP, st.a1_step);
		write_reg(SEL_A2_STEP, {16'h0000, st.a2_step});
		write_reg(SEL_A1_PTR, a1);
		write_reg(SEL_A2_PTR, {16'h0000, a2});
		write_reg(SEL_COUNT, {n, inner});
		write_reg(SEL_CMD, cmd_word);
		wait_busy(got);
		if (got)
			check_breq(test_name, exp_breq, breq);
		else begin
			$display("Sequencer never left idle in test %s", test_name);
			other_errs++;
		end
		wait_int(INT_TIMEOUT, got);
		if (!got) begin
			$display("No blit_int within %0d cycles in test %s", INT_TIMEOUT, test_name);
			other_errs++;
			exp_q.delete();
		end
		stopped = 1'b0;
	endtask

	// Compare process, mid-cycle where the DUT outputs are settled
	always @(negedge sys_clk) begin
		ptrs_t exp_ptrs;
		if (resetl && blit_int === 1'b1) begin
			int_cnt++;
			if (exp_q.size() == 0) begin
				$display("Unexpected blit_int in test %s", test_name);
				other_errs++;
			end else begin
				exp_ptrs = exp_q.pop_front();
				check_ptr_a1(test_name, exp_ptrs.a1, a1_ptr);
				check_ptr_a2(test_name, exp_ptrs.a2, a2_ptr);
				check_status(test_name, idle_only, status);
				check_breq(test_name, 2'b00, breq);
			end
		end
	end

	initial begin
		ptr_a1_t a1;
		ptr_a2_t a2;
		step_t st;
		cmd_t flags;
		count_t n;
		count_t inner;
		logic [31:0] rnd;
		bit got;
		int base_cnt;
		int k;
		idle_only = '0;
		idle_only.idle = 1'b1;
		resetl = 1'b0;
		cmd_wr = 1'b0;
		count_wr = 1'b0;
		a1_step_wr = 1'b0;
		a2_step_wr = 1'b0;
		a1_ptr_wr = 1'b0;
		a2_ptr_wr = 1'b0;
		din = '0;
		stopped = 1'b0;
		repeat (16) @(posedge sys_clk);
		#1;
		resetl = 1'b1;

		// Idle after reset, any blit_int here is flagged by the compare process
		check_status(test_name, idle_only, status);
		check_breq(test_name, 2'b00, breq);
		wait_int(50, got);

		// One line, so no update round
		test_name = "single_line";
		flags = '0;
		flags.upd_a1f = 1'b1;
		flags.upd_a1 = 1'b1;
		flags.upd_a2 = 1'b1;
		a1 = 32'h0012_8000;
		a2 = 16'h0345;
		st.a1_step = 32'h0003_9000;
		st.a2_step = 16'h0010;
		base_cnt = int_cnt;
		run_blit(16'd1, 16'd3, flags, a1, a2, st, 1'b0);
		repeat (30) next_cycle();
		if (int_cnt != base_cnt + 1) begin
			$display("ERR %s expected %0d actual %0d", test_name, base_cnt + 1, int_cnt);
			val_errs++;
		end
		check_ptr_a1(test_name, a1, a1_ptr);
		check_ptr_a2(test_name, a2, a2_ptr);

		// Fraction wraps on the first round only
		test_name = "frac_carry";
		flags = '0;
		flags.upd_a1f = 1'b1;
		flags.upd_a1 = 1'b1;
		a1 = 32'h0100_C000;
		st.a1_step = 32'h0002_8000;
		run_blit(16'd3, 16'd2, flags, a1, a2, st, 1'b0);
		check_ptr_a1(test_name, 32'h0105_C000, a1_ptr);

		for (k = 0; k < 12; k++) begin
			test_name = $sformatf("random_%0d", k);
			n = 16'(2 + ($unsigned($random(seed)) % 7));
			inner = 16'(1 + ($unsigned($random(seed)) % 4));
			rnd = $random(seed);
			flags = '0;
			flags.upd_a1f = rnd[0];
			flags.upd_a1 = rnd[1];
			flags.upd_a2 = rnd[2];
			flags.bus_hi = rnd[3];
			a1 = $random(seed);
			a2 = 16'($random(seed));
			st.a1_step = $random(seed);
			st.a2_step = 16'($random(seed));
			run_blit(n, inner, flags, a1, a2, st, 1'b0);
		end

		// Bus priority levels, then stopped masking both
		test_name = "bus_hi";
		flags = '0;
		flags.bus_hi = 1'b1;
		flags.upd_a2 = 1'b1;
		run_blit(16'd4, 16'd2, flags, a1, a2, st, 1'b0);
		test_name = "bus_lo";
		flags.bus_hi = 1'b0;
		run_blit(16'd4, 16'd2, flags, a1, a2, st, 1'b0);
		test_name = "stopped";
		flags.bus_hi = 1'b1;
		run_blit(16'd4, 16'd2, flags, a1, a2, st, 1'b1);

		// Held command never starts and status stays idle throughout
		test_name = "hold";
		write_reg(SEL_COUNT, {16'd2, 16'd2});
		write_reg(SEL_CMD, 32'h1 << CMD_HOLD_BIT);
		for (k = 0; k < 100; k++) begin
			next_cycle();
			check_status(test_name, idle_only, status);
		end

		$display("Run complete: %0d value errors, %0d other errors", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: files.f
source/blit_cmd_pkg.sv
source/blit_addr_pkg.sv
source/blit_cmd_regs.sv
source/blit_outer.sv
source/blit_inner.sv
source/blit_addr_update.sv
source/blit_core.sv
tests/blit_core_assert.sv
tests/blit_core_tb.sv

// File: Bender.yml
package:
  name: blit_core

sources:
  # Packages first, then the blocks, then the top level
  - source/blit_cmd_pkg.sv
  - source/blit_addr_pkg.sv
  - source/blit_cmd_regs.sv
  - source/blit_outer.sv
  - source/blit_inner.sv
  - source/blit_addr_update.sv
  - source/blit_core.sv

  - target: test
    files:
      - tests/blit_core_assert.sv
      - tests/blit_core_tb.sv
